/* Makefile */
VERILATOR ?= verilator
TOP       ?= apb_i2c_bridge_tb
FILELIST  ?= apb_i2c_bridge.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* apb_i2c_bridge.f */
+incdir+verilog
verilog/i2c_bridge_pkg.sv
verilog/byte_fifo.sv
verilog/apb_i2c_regs.sv
verilog/i2c_master.sv
verilog/apb_i2c_bridge.sv
tests/i2c_target_model.sv
tests/apb_i2c_bridge_tb.sv

/* tests/apb_i2c_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "i2c_bridge_settings.svh"

module apb_i2c_bridge_tb;

	import i2c_bridge_pkg::*;

	localparam int CLK_PERIOD    = 100;
	localparam int XFER_PRESCALE = 4;
	localparam int APB_ACCESSES  = 100;

	logic                      clk;
	logic                      rst_n;
	logic [`BRIDGE_ADDR_W-1:0] paddr;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [`BRIDGE_DATA_W-1:0] pwdata;
	wire  [`BRIDGE_DATA_W-1:0] prdata;
	wire                       pready;
	wire                       scl_oe;
	wire                       sda_oe;
	wire                       target_sda_oe;
	wire                       scl_line;
	wire                       sda_line;
	logic [7:0]                target_rd [16];
	logic [7:0]                target_log [16];
	logic [7:0]                target_count;
	logic [7:0]                target_reads;
	logic [15:0]               target_acks;
	int                        checks;
	int                        errors;

	// open-drain lines with pull-ups
	assign scl_line = !scl_oe;
	assign sda_line = !(sda_oe || target_sda_oe);

	apb_i2c_bridge apb_i2c_bridge_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.scl_oe  (scl_oe),
		.sda_oe  (sda_oe),
		.scl_in  (scl_line),
		.sda_in  (sda_line)
	);

	i2c_target_model #(.ADDRESS(7'h2a)) target_inst (
		.scl         (scl_line),
		.sda         (sda_line),
		.read_data   (target_rd),
		.sda_oe      (target_sda_oe),
		.write_log   (target_log),
		.write_count (target_count),
		.read_count  (target_reads),
		.master_ack  (target_acks)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check(input logic [7:0] got, input logic [7:0] expected, input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("mismatch at time %0d ns: %s, got %02h, expected %02h",
				$time, what, got, expected);
		end
	endtask

	task automatic apb_write(input reg_addr_e addr, input logic [7:0] data);
		@(posedge clk);
		paddr   <= addr;
		pwdata  <= data;
		pwrite  <= 1'b1;
		psel    <= 1'b1;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check({7'b0000000, pready}, 8'h01, "pready during write access");
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input reg_addr_e addr, output logic [7:0] data);
		@(posedge clk);
		paddr   <= addr;
		pwrite  <= 1'b0;
		psel    <= 1'b1;
		@(posedge clk);
		penable <= 1'b1;
		// prdata is combinational during ACCESS
		@(negedge clk);
		data = prdata;
		check({7'b0000000, pready}, 8'h01, "pready during read access");
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_idle;
		logic [7:0] st;
		st = 8'h10;
		while (st[4])
			apb_read(REG_STATUS, st);
	endtask

	task automatic start_transfer(input logic [7:0] target_byte, input logic [7:0] count);
		apb_write(REG_TARGET, target_byte);
		apb_write(REG_COUNT, count);
		apb_write(REG_PRESCALE, 8'(XFER_PRESCALE));
		apb_write(REG_CTRL, 8'h01);
		wait_idle();
	endtask

	task automatic write_readback(input reg_addr_e addr, input string name);
		logic [7:0] val;
		logic [7:0] rd;
		val = 8'($urandom);
		apb_write(addr, val);
		apb_read(addr, rd);
		check(rd, val, {name, " readback"});
	endtask

	task automatic reset_and_regs;
		logic [7:0] rd;
		@(negedge clk);
		check({6'b000000, scl_oe, sda_oe}, 8'h00, "bus drive after reset");
		apb_read(REG_STATUS, rd);
		check(rd, 8'h05, "status after reset");
		apb_read(REG_PRESCALE, rd);
		check(rd, 8'(`BRIDGE_PRESCALE_RST), "prescale after reset");
		apb_read(REG_TARGET, rd);
		check(rd, 8'h00, "target after reset");
		apb_read(REG_COUNT, rd);
		check(rd, 8'h00, "count after reset");
		write_readback(REG_TARGET, "target");
		write_readback(REG_COUNT, "count");
		write_readback(REG_PRESCALE, "prescale");
	endtask

	task automatic write_transfer;
		logic [7:0] bytes [3];
		logic [7:0] rd;
		for (int i = 0; i < 3; i++) begin
			bytes[i] = 8'($urandom);
			apb_write(REG_TXDATA, bytes[i]);
		end
		start_transfer({7'h2a, 1'b0}, 8'd3);
		apb_read(REG_STATUS, rd);
		check(rd, 8'h05, "status after write transfer");
		check(target_count, 8'd4, "bytes seen by target");
		check(target_log[0], {7'h2a, 1'b0}, "write address byte");
		for (int i = 0; i < 3; i++)
			check(target_log[i + 1], bytes[i], $sformatf("written byte %0d", i));
	endtask

	task automatic read_transfer;
		logic [7:0] bytes [4];
		logic [7:0] rd;
		for (int i = 0; i < 4; i++) begin
			bytes[i]     = 8'($urandom);
			target_rd[i] <= bytes[i];
		end
		start_transfer({7'h2a, 1'b1}, 8'd4);
		apb_read(REG_STATUS, rd);
		check(rd, 8'h01, "status after read transfer");
		for (int i = 0; i < 4; i++) begin
			apb_read(REG_RXDATA, rd);
			check(rd, bytes[i], $sformatf("read byte %0d", i));
		end
		apb_read(REG_STATUS, rd);
		check(rd, 8'h05, "status after draining rx");
		check(target_log[0], {7'h2a, 1'b1}, "read address byte");
		check(target_reads, 8'd4, "bytes sent by target");
		// ack on the first three, nack on the last
		check(target_acks[7:0], 8'h07, "master ack pattern");
	endtask

	task automatic address_nack;
		logic [7:0] rd;
		repeat (2)
			apb_write(REG_TXDATA, 8'($urandom));
		start_transfer({7'h15, 1'b0}, 8'd2);
		apb_read(REG_STATUS, rd);
		check(rd, 8'h24, "status after address nack");
		check(target_count, 8'd1, "bytes seen on nack");
		// two bytes left, so depth minus two more fill it
		repeat (`BRIDGE_FIFO_DEPTH - 3)
			apb_write(REG_TXDATA, 8'($urandom));
		apb_read(REG_STATUS, rd);
		check(rd, 8'h24, "tx one short of full");
		apb_write(REG_TXDATA, 8'($urandom));
		apb_read(REG_STATUS, rd);
		check(rd, 8'h26, "tx full after refill");
		apb_write(REG_CTRL, 8'h08);
		apb_read(REG_STATUS, rd);
		check(rd, 8'h06, "status after nack clear");
		apb_write(REG_CTRL, 8'h02);
		apb_read(REG_STATUS, rd);
		check(rd, 8'h05, "status after tx flush");
	endtask

	task automatic fifo_limits;
		logic [7:0] bytes [`BRIDGE_FIFO_DEPTH + 1];
		logic [7:0] rd;
		for (int i = 0; i <= `BRIDGE_FIFO_DEPTH; i++) begin
			bytes[i] = 8'($urandom);
			apb_write(REG_TXDATA, bytes[i]);
		end
		apb_read(REG_STATUS, rd);
		check(rd, 8'h06, "status after overfill");
		apb_read(REG_RXDATA, rd);
		check(rd, 8'h00, "read of empty rx");
		start_transfer({7'h2a, 1'b0}, 8'(`BRIDGE_FIFO_DEPTH));
		apb_read(REG_STATUS, rd);
		check(rd, 8'h05, "status after full write");
		check(target_count, 8'(`BRIDGE_FIFO_DEPTH + 1), "bytes seen on full write");
		for (int i = 0; i < `BRIDGE_FIFO_DEPTH; i++)
			check(target_log[i + 1], bytes[i], $sformatf("fifo byte %0d", i));
	endtask

	// worst case clocks of one transfer, halves of SCL plus FIFO waits
	function automatic int transfer_cycles(input int bytes);
		return ((bytes + 1) * 18 + 6) * (XFER_PRESCALE + 1) + bytes + 8;
	endfunction

	initial begin : watchdog
		int limit;
		limit = transfer_cycles(3) + transfer_cycles(4) + transfer_cycles(0)
			+ transfer_cycles(`BRIDGE_FIFO_DEPTH) + APB_ACCESSES * 4 + 4;
		limit = limit * 3 / 2;
		repeat (limit) @(posedge clk);
		$display("timeout: tests still running after %0d clock cycles", limit);
		$display("Regression failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h45aa));
		checks  = 0;
		errors  = 0;
		rst_n   = 1'b0;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		for (int i = 0; i < 16; i++)
			target_rd[i] = 8'h00;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		reset_and_regs();
		write_transfer();
		read_transfer();
		address_nack();
		fifo_limits();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/i2c_target_model.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_target_model #(
	parameter logic [6:0] ADDRESS = 7'h2a
) (
	input  wire         scl,
	input  wire         sda,
	input  wire  [7:0]  read_data [16],
	output logic        sda_oe,
	output logic [7:0]  write_log [16],
	output logic [7:0]  write_count,
	output logic [7:0]  read_count,
	output logic [15:0] master_ack
);

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_ADDR,
		PH_WRITE,
		PH_READ,
		PH_SLAVE_ACK,
		PH_MASTER_ACK
	} phase_e;

	phase_e     phase;
	logic       scl_q;
	logic       sda_q;
	logic       reading;
	logic       acked;
	logic [3:0] bits;
	logic [7:0] shreg;
	logic [7:0] out_byte;

	// one process watches both lines and owns every output
	initial begin
		sda_oe      = 1'b0;
		write_count = 8'h00;
		read_count  = 8'h00;
		master_ack  = 16'h0000;
		phase       = PH_IDLE;
		scl_q       = 1'b1;
		sda_q       = 1'b1;
		reading     = 1'b0;
		acked       = 1'b0;
		bits        = 4'd0;
		shreg       = 8'h00;
		out_byte    = 8'h00;
		for (int i = 0; i < 16; i++)
			write_log[i] = 8'h00;
		forever begin
			@(scl or sda);
			if (scl && scl_q && sda_q && !sda) begin
				// start condition, the log restarts per transfer
				phase       = PH_ADDR;
				bits        = 4'd0;
				write_count = 8'h00;
				read_count  = 8'h00;
				master_ack  = 16'h0000;
				sda_oe      = 1'b0;
			end else if (scl && scl_q && !sda_q && sda) begin
				phase  = PH_IDLE;
				sda_oe = 1'b0;
			end else if (scl && !scl_q) begin
				case (phase)
					PH_ADDR, PH_WRITE: begin
						shreg = {shreg[6:0], sda};
						bits  = bits + 4'd1;
					end
					PH_READ: bits = bits + 4'd1;
					PH_MASTER_ACK: begin
						acked                        = !sda;
						master_ack[read_count[3:0]] = !sda;
						read_count                   = read_count + 8'd1;
					end
					default: ;
				endcase
			end else if (!scl && scl_q) begin
				case (phase)
					PH_ADDR: begin
						if (bits == 4'd8) begin
							write_log[write_count[3:0]] = shreg;
							write_count = write_count + 8'd1;
							if (shreg[7:1] == ADDRESS) begin
								reading = shreg[0];
								sda_oe  = 1'b1;
								phase   = PH_SLAVE_ACK;
							end else begin
								phase = PH_IDLE;
							end
						end
					end
					PH_WRITE: begin
						if (bits == 4'd8) begin
							write_log[write_count[3:0]] = shreg;
							write_count = write_count + 8'd1;
							sda_oe = 1'b1;
							phase  = PH_SLAVE_ACK;
						end
					end
					PH_SLAVE_ACK: begin
						bits = 4'd0;
						if (reading) begin
							out_byte = read_data[read_count[3:0]];
							sda_oe   = !out_byte[7];
							phase    = PH_READ;
						end else begin
							sda_oe = 1'b0;
							phase  = PH_WRITE;
						end
					end
					PH_READ: begin
						if (bits == 4'd8) begin
							sda_oe = 1'b0;
							phase  = PH_MASTER_ACK;
						end else begin
							sda_oe = !out_byte[3'd7 - bits[2:0]];
						end
					end
					PH_MASTER_ACK: begin
						// nack from the master ends the read
						if (acked) begin
							bits     = 4'd0;
							out_byte = read_data[read_count[3:0]];
							sda_oe   = !out_byte[7];
							phase    = PH_READ;
						end else begin
							phase = PH_IDLE;
						end
					end
					default: ;
				endcase
			end
			scl_q = scl;
			sda_q = sda;
		end
	end

endmodule

`default_nettype wire

/* verilog/apb_i2c_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "i2c_bridge_settings.svh"

module apb_i2c_bridge (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire  [`BRIDGE_ADDR_W-1:0]  paddr,
	input  wire                        psel,
	input  wire                        penable,
	input  wire                        pwrite,
	input  wire  [`BRIDGE_DATA_W-1:0]  pwdata,
	output wire  [`BRIDGE_DATA_W-1:0]  prdata,
	output wire                        pready,
	output wire                        scl_oe,
	output wire                        sda_oe,
	input  wire                        scl_in,
	input  wire                        sda_in
);

	import i2c_bridge_pkg::*;

	i2c_cmd_t                  cmd;
	i2c_status_t               status;
	fifo_flags_t               tx_flags;
	fifo_flags_t               rx_flags;
	logic                      nack_clear;
	logic                      tx_push;
	logic                      tx_pop;
	logic                      tx_flush;
	logic [`BRIDGE_DATA_W-1:0] tx_wr_data;
	logic [`BRIDGE_DATA_W-1:0] tx_rd_data;
	logic                      rx_push;
	logic                      rx_pop;
	logic                      rx_flush;
	logic [`BRIDGE_DATA_W-1:0] rx_wr_data;
	logic [`BRIDGE_DATA_W-1:0] rx_rd_data;

	apb_i2c_regs apb_i2c_regs_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.tx_push    (tx_push),
		.tx_data    (tx_wr_data),
		.tx_flush   (tx_flush),
		.rx_pop     (rx_pop),
		.rx_flush   (rx_flush),
		.tx_flags   (tx_flags),
		.rx_flags   (rx_flags),
		.rx_data    (rx_rd_data),
		.status     (status),
		.cmd        (cmd),
		.nack_clear (nack_clear)
	);

	// processor to bus
	byte_fifo #(.DEPTH(`BRIDGE_FIFO_DEPTH)) tx_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (tx_flush),
		.push      (tx_push),
		.push_data (tx_wr_data),
		.pop       (tx_pop),
		.pop_data  (tx_rd_data),
		.flags     (tx_flags)
	);

	// bus to processor
	byte_fifo #(.DEPTH(`BRIDGE_FIFO_DEPTH)) rx_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (rx_flush),
		.push      (rx_push),
		.push_data (rx_wr_data),
		.pop       (rx_pop),
		.pop_data  (rx_rd_data),
		.flags     (rx_flags)
	);

	i2c_master i2c_master_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.nack_clear (nack_clear),
		.status     (status),
		.tx_pop     (tx_pop),
		.tx_data    (tx_rd_data),
		.tx_flags   (tx_flags),
		.rx_push    (rx_push),
		.rx_data    (rx_wr_data),
		.rx_flags   (rx_flags),
		.scl_oe     (scl_oe),
		.sda_oe     (sda_oe),
		.scl_in     (scl_in),
		.sda_in     (sda_in)
	);

endmodule

`default_nettype wire

/* verilog/apb_i2c_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "i2c_bridge_settings.svh"

module apb_i2c_regs (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire        [`BRIDGE_ADDR_W-1:0]  paddr,
	input  wire                              psel,
	input  wire                              penable,
	input  wire                              pwrite,
	input  wire        [`BRIDGE_DATA_W-1:0]  pwdata,
	output logic       [`BRIDGE_DATA_W-1:0]  prdata,
	output logic                             pready,
	output logic                             tx_push,
	output logic       [`BRIDGE_DATA_W-1:0]  tx_data,
	output logic                             tx_flush,
	output logic                             rx_pop,
	output logic                             rx_flush,
	input  wire i2c_bridge_pkg::fifo_flags_t tx_flags,
	input  wire i2c_bridge_pkg::fifo_flags_t rx_flags,
	input  wire        [`BRIDGE_DATA_W-1:0]  rx_data,
	input  wire i2c_bridge_pkg::i2c_status_t status,
	output i2c_bridge_pkg::i2c_cmd_t         cmd,
	output logic                             nack_clear
);

	import i2c_bridge_pkg::*;

	reg_addr_e                 addr;
	logic                      wr_en;
	logic                      rd_en;
	logic [3:0]                ctrl_q;
	logic [6:0]                target_q;
	logic                      read_q;
	logic [`BRIDGE_DATA_W-1:0] count_q;
	logic [`BRIDGE_DATA_W-1:0] prescale_q;

	assign addr   = reg_addr_e'(paddr);
	assign pready = 1'b1;

	// zero wait states, so ACCESS always completes
	assign wr_en = psel && penable && pwrite;
	assign rd_en = psel && penable && !pwrite;

	assign tx_push = wr_en && (addr == REG_TXDATA) && !tx_flags.full;
	assign tx_data = pwdata;
	assign rx_pop  = rd_en && (addr == REG_RXDATA) && !rx_flags.empty;

	// ctrl bits live for one cycle after the write
	assign tx_flush   = ctrl_q[1];
	assign rx_flush   = ctrl_q[2];
	assign nack_clear = ctrl_q[3];

	assign cmd = '{
		start:    ctrl_q[0],
		target:   target_q,
		read:     read_q,
		count:    count_q,
		prescale: prescale_q
	};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl_q     <= '0;
			target_q   <= '0;
			read_q     <= 1'b0;
			count_q    <= '0;
			prescale_q <= `BRIDGE_PRESCALE_RST;
		end else begin
			ctrl_q <= '0;
			if (wr_en) begin
				case (addr)
					REG_CTRL: begin
						// start is dropped while a transfer runs
						ctrl_q <= {pwdata[3:1], pwdata[0] && !status.busy};
					end
					REG_TARGET: begin
						target_q <= pwdata[7:1];
						read_q   <= pwdata[0];
					end
					REG_COUNT:    count_q    <= pwdata;
					REG_PRESCALE: prescale_q <= pwdata;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (addr)
			REG_CTRL:   prdata = {4'b0000, ctrl_q};
			REG_STATUS: begin
				prdata = {2'b00, status.nack, status.busy,
					rx_flags.full, rx_flags.empty, tx_flags.full, tx_flags.empty};
			end
			// empty rx reads as zero
			REG_RXDATA:   prdata = rx_flags.empty ? '0 : rx_data;
			REG_TARGET:   prdata = {target_q, read_q};
			REG_COUNT:    prdata = count_q;
			REG_PRESCALE: prdata = prescale_q;
			default:      prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/byte_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "i2c_bridge_settings.svh"

module byte_fifo #(
	parameter int DEPTH = `BRIDGE_FIFO_DEPTH
) (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             flush,
	input  wire                             push,
	input  wire        [`BRIDGE_DATA_W-1:0] push_data,
	input  wire                             pop,
	output logic       [`BRIDGE_DATA_W-1:0] pop_data,
	output i2c_bridge_pkg::fifo_flags_t     flags
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [`BRIDGE_DATA_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]          wr_ptr;
	logic [PTR_W-1:0]          rd_ptr;
	logic [CNT_W-1:0]          count;
	logic                      do_push;
	logic                      do_pop;

	assign flags = '{full: (count == CNT_W'(DEPTH)), empty: (count == '0)};

	// full and empty guard the pointers
	assign do_push = push && !flags.full;
	assign do_pop  = pop && !flags.empty;

	// head is visible without a read cycle
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/i2c_bridge_pkg.sv */
`default_nettype none

`include "i2c_bridge_settings.svh"

package i2c_bridge_pkg;

	// APB register map
	typedef enum logic [`BRIDGE_ADDR_W-1:0] {
		REG_CTRL     = 4'd0,
		REG_STATUS   = 4'd1,
		REG_TXDATA   = 4'd2,
		REG_RXDATA   = 4'd3,
		REG_TARGET   = 4'd4,
		REG_COUNT    = 4'd5,
		REG_PRESCALE = 4'd6
	} reg_addr_e;

	typedef enum logic [2:0] {
		IDLE,
		START,
		ADDR,
		ADDR_ACK,
		WAIT_DATA,
		DATA,
		DATA_ACK,
		STOP
	} master_state_e;

	typedef struct packed {
		logic                      start;
		logic [6:0]                target;
		logic                      read;
		logic [`BRIDGE_DATA_W-1:0] count;
		logic [`BRIDGE_DATA_W-1:0] prescale;
	} i2c_cmd_t;

	typedef struct packed {
		logic busy;
		logic nack;
	} i2c_status_t;

	typedef struct packed {
		logic full;
		logic empty;
	} fifo_flags_t;

endpackage

`default_nettype wire

/* verilog/i2c_bridge_settings.svh */
`ifndef I2C_BRIDGE_SETTINGS_SVH
`define I2C_BRIDGE_SETTINGS_SVH

// APB address width
`define BRIDGE_ADDR_W 4

// APB data width, also the I2C byte width
`define BRIDGE_DATA_W 8

// entries per FIFO
`define BRIDGE_FIFO_DEPTH 8

// SCL half-period is prescale+1 clocks
`define BRIDGE_PRESCALE_RST 4

`endif

/* verilog/i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "i2c_bridge_settings.svh"

module i2c_master (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire i2c_bridge_pkg::i2c_cmd_t    cmd,
	input  wire                              nack_clear,
	output i2c_bridge_pkg::i2c_status_t      status,
	output logic                             tx_pop,
	input  wire        [`BRIDGE_DATA_W-1:0]  tx_data,
	input  wire i2c_bridge_pkg::fifo_flags_t tx_flags,
	output logic                             rx_push,
	output logic       [`BRIDGE_DATA_W-1:0]  rx_data,
	input  wire i2c_bridge_pkg::fifo_flags_t rx_flags,
	output logic                             scl_oe,
	output logic                             sda_oe,
	input  wire                              scl_in,
	input  wire                              sda_in
);

	import i2c_bridge_pkg::*;

	master_state_e             state;
	master_state_e             bit_next;
	logic                      busy_q;
	logic                      nack_q;
	logic                      high_half;
	logic                      sda_want;
	logic [6:0]                target_q;
	logic                      read_q;
	logic [`BRIDGE_DATA_W-1:0] prescale_q;
	logic [`BRIDGE_DATA_W-1:0] bytes_left;
	logic [`BRIDGE_DATA_W-1:0] div_cnt;
	logic [`BRIDGE_DATA_W-1:0] shift;
	logic [2:0]                bit_cnt;
	logic                      tick;
	logic                      bit_end;
	logic                      last_bit;
	logic                      data_ready;
	logic                      got_nack;

	assign status = '{busy: busy_q, nack: nack_q};

	assign tick     = (div_cnt == '0);
	// end of the SCL high half, the moment SCL is pulled low again
	assign bit_end  = tick && high_half && scl_in;
	assign last_bit = (bit_cnt == 3'd7);

	// a write needs a byte to send, a read needs room for one
	assign data_ready = read_q ? !rx_flags.full : !tx_flags.empty;
	assign tx_pop     = (state == WAIT_DATA) && !read_q && !tx_flags.empty;

	// ack from the target reads as a low SDA
	assign got_nack = sda_in && ((state == ADDR_ACK) || (state == DATA_ACK && !read_q));

	// SDA level to hold during the SCL low half
	always_comb begin
		case (state)
			ADDR:     sda_want = !shift[7];
			DATA:     sda_want = !read_q && !shift[7];
			// master acks every read byte but the last
			DATA_ACK: sda_want = read_q && (bytes_left != 8'd1);
			STOP:     sda_want = 1'b1;
			default:  sda_want = 1'b0;
		endcase
	end

	always_comb begin
		case (state)
			START:    bit_next = ADDR;
			ADDR:     bit_next = last_bit ? ADDR_ACK : ADDR;
			ADDR_ACK: bit_next = (sda_in || bytes_left == '0) ? STOP : WAIT_DATA;
			DATA:     bit_next = last_bit ? DATA_ACK : DATA;
			DATA_ACK: bit_next = (got_nack || bytes_left == 8'd1) ? STOP : WAIT_DATA;
			default:  bit_next = STOP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			busy_q    <= 1'b0;
			nack_q    <= 1'b0;
			high_half <= 1'b0;
			scl_oe    <= 1'b0;
			sda_oe    <= 1'b0;
			rx_push   <= 1'b0;
		end else begin
			rx_push <= 1'b0;
			if (nack_clear)
				nack_q <= 1'b0;
			// SDA only moves while SCL is held low
			if (scl_oe && !high_half)
				sda_oe <= sda_want;
			case (state)
				IDLE: begin
					if (cmd.start) begin
						state     <= START;
						busy_q    <= 1'b1;
						high_half <= 1'b0;
					end
				end
				WAIT_DATA: begin
					if (data_ready)
						state <= DATA;
				end
				default: begin
					if (tick && !high_half) begin
						high_half <= 1'b1;
						scl_oe    <= 1'b0;
						// start condition, SDA falls with SCL high
						if (state == START)
							sda_oe <= 1'b1;
					end else if (tick && state == STOP) begin
						if (sda_oe) begin
							sda_oe <= 1'b0;
						end else begin
							state     <= IDLE;
							busy_q    <= 1'b0;
							high_half <= 1'b0;
						end
					end else if (bit_end) begin
						high_half <= 1'b0;
						scl_oe    <= 1'b1;
						state     <= bit_next;
						if (got_nack)
							nack_q <= 1'b1;
						if (state == DATA && last_bit && read_q)
							rx_push <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (cmd.start) begin
					target_q   <= cmd.target;
					read_q     <= cmd.read;
					prescale_q <= cmd.prescale;
					bytes_left <= cmd.count;
					div_cnt    <= cmd.prescale;
				end
			end
			WAIT_DATA: begin
				div_cnt <= prescale_q;
				bit_cnt <= '0;
				if (tx_pop)
					shift <= tx_data;
			end
			default: begin
				div_cnt <= tick ? prescale_q : div_cnt - 1'b1;
				if (bit_end) begin
					case (state)
						START: begin
							shift   <= {target_q, read_q};
							bit_cnt <= '0;
						end
						ADDR, DATA: begin
							shift   <= {shift[6:0], sda_in};
							bit_cnt <= bit_cnt + 1'b1;
						end
						DATA_ACK: bytes_left <= bytes_left - 1'b1;
						default: ;
					endcase
				end
			end
		endcase
	end

	// received byte, pushed by rx_push on the eighth bit
	always_ff @(posedge clk) begin
		if (bit_end && state == DATA)
			rx_data <= {shift[6:0], sda_in};
	end

endmodule

`default_nettype wire
